// ==== rtl/cache_cfg_pkg.sv ====
// cache geometry constants and the split address type
package cache_cfg_pkg;

    // word and address space
    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 16;

    // total capacity and line size in bytes
    localparam int CACHE_SIZE   = 256;
    localparam int LINE_BYTES   = 16;
    localparam int WORD_BYTES   = DATA_WIDTH / 8;

    // derived geometry of the direct-mapped array
    localparam int INDEX_COUNT  = CACHE_SIZE / LINE_BYTES;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int INDEX_WIDTH  = $clog2(INDEX_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH   = LINE_BYTES * 8;

    // byte address split into its lookup fields, msb first
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } addr_t;

endpackage

// ==== rtl/cache_bus_pkg.sv ====
// request opcodes, controller states, and processor and memory bus structs
package cache_bus_pkg;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } cache_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB_REQ,
        S_WB_WAIT,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_DONE
    } ctrl_state_e;

    // valid is a single-cycle strobe from the processor
    typedef struct packed {
        logic                              valid;
        cache_op_e                         op;
        cache_cfg_pkg::addr_t              addr;
        logic [cache_cfg_pkg::DATA_WIDTH-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                              done;
        logic [cache_cfg_pkg::DATA_WIDTH-1:0] rdata;
    } cpu_rsp_t;

    // line address is the tag followed by the index
    typedef struct packed {
        logic                              rd;
        logic                              wr;
        logic [cache_cfg_pkg::TAG_WIDTH+cache_cfg_pkg::INDEX_WIDTH-1:0] line_addr;
        logic [cache_cfg_pkg::LINE_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                              ack;
        logic [cache_cfg_pkg::LINE_WIDTH-1:0] rdata;
    } mem_rsp_t;

endpackage

// ==== rtl/dp_ram.sv ====
// dual-port RAM with combinational read and clocked write
`timescale 1ns/1ps

module dp_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int RAM_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_ram_rd_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_rd_addr,
    output logic [DATA_WIDTH-1:0]        o_ram_rd_data,
    input  logic                         i_ram_wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_ram_wr_addr,
    input  logic [DATA_WIDTH-1:0]        i_ram_wr_data
);

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

    // a disabled read port returns zero so unused lookups stay quiet
    assign o_ram_rd_data = i_ram_rd_en ? mem[i_ram_rd_addr] : '0;

    // writes are held off while reset is asserted
    always_ff @(posedge clk) begin
        if (n_rst && i_ram_wr_en) begin
            mem[i_ram_wr_addr] <= i_ram_wr_data;
        end
    end

endmodule

// ==== rtl/cache.sv ====
// direct-mapped cache array with per-line valid and dirty state, hit check and line merge
`timescale 1ns/1ps

module cache (
    input  logic                                 clk,
    input  logic                                 n_rst,

    // re reads, we updates one word on a hit, fe replaces the whole line
    input  logic                                 i_cache_re,
    input  logic                                 i_cache_we,
    input  logic                                 i_cache_fe,
    // valid flag written with a fill, low to invalidate the line
    input  logic                                 i_cache_valid,
    input  logic [cache_cfg_pkg::OFFSET_WIDTH-1:0] i_cache_offset,
    input  logic [cache_cfg_pkg::INDEX_WIDTH-1:0]  i_cache_index,
    input  logic [cache_cfg_pkg::TAG_WIDTH-1:0]    i_cache_tag,
    input  logic [cache_cfg_pkg::LINE_WIDTH-1:0]   i_cache_fdata,
    input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]   i_cache_wdata,

    // line status and victim contents for the addressed index
    output logic                                 o_cache_valid,
    output logic                                 o_cache_dirty,
    output logic                                 o_cache_hit,
    output logic [cache_cfg_pkg::TAG_WIDTH-1:0]    o_cache_tag,
    output logic [cache_cfg_pkg::LINE_WIDTH-1:0]   o_cache_vdata,
    output logic [cache_cfg_pkg::DATA_WIDTH-1:0]   o_cache_rdata
);

    import cache_cfg_pkg::*;

    typedef struct packed {
        logic valid;
        logic dirty;
    } line_state_t;

    line_state_t             line_state_q [INDEX_COUNT];
    line_state_t             cur_state;
    logic                    line_hit;
    logic                    word_we;
    logic                    ram_re;
    logic [OFFSET_WIDTH-1:0] byte_sel [WORD_BYTES];
    logic [LINE_WIDTH-1:0]   data_rd;
    logic [LINE_WIDTH-1:0]   data_wr;
    logic [TAG_WIDTH-1:0]    tag_rd;

    assign cur_state = line_state_q[i_cache_index];
    assign line_hit  = cur_state.valid && (tag_rd == i_cache_tag);

    // a word write only lands when the tag matches
    assign word_we   = i_cache_we && line_hit;

    // the old line is read out for every access so merges see it
    assign ram_re    = i_cache_re || i_cache_we || i_cache_fe;

    assign o_cache_valid = cur_state.valid;
    assign o_cache_dirty = cur_state.dirty;
    assign o_cache_hit   = line_hit;
    assign o_cache_tag   = tag_rd;
    assign o_cache_vdata = data_rd;

    // byte lane positions inside the line for each byte of the word
    for (genvar g = 0; g < WORD_BYTES; g++) begin : g_byte_sel
        assign byte_sel[g] = i_cache_offset + OFFSET_WIDTH'(g);
    end

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            o_cache_rdata[i*8 +: 8] = data_rd[byte_sel[i]*8 +: 8];
        end
    end

    // untouched bytes are written back as read
    always_comb begin
        data_wr = data_rd;
        if (word_we) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                data_wr[byte_sel[i]*8 +: 8] = i_cache_wdata[i*8 +: 8];
            end
        end else if (i_cache_fe) begin
            data_wr = i_cache_fdata;
        end
    end

    // a fill always leaves the line clean
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < INDEX_COUNT; i++) begin
                line_state_q[i] <= '0;
            end
        end else if (i_cache_fe) begin
            line_state_q[i_cache_index] <= '{valid: i_cache_valid, dirty: 1'b0};
        end else if (word_we) begin
            line_state_q[i_cache_index].dirty <= 1'b1;
        end
    end

    dp_ram #(
        .DATA_WIDTH(LINE_WIDTH),
        .RAM_DEPTH (INDEX_COUNT)
    ) data_ram (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_ram_rd_en  (ram_re),
        .i_ram_rd_addr(i_cache_index),
        .o_ram_rd_data(data_rd),
        .i_ram_wr_en  (word_we || i_cache_fe),
        .i_ram_wr_addr(i_cache_index),
        .i_ram_wr_data(data_wr)
    );

    dp_ram #(
        .DATA_WIDTH(TAG_WIDTH),
        .RAM_DEPTH (INDEX_COUNT)
    ) tag_ram (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_ram_rd_en  (ram_re),
        .i_ram_rd_addr(i_cache_index),
        .o_ram_rd_data(tag_rd),
        .i_ram_wr_en  (i_cache_fe),
        .i_ram_wr_addr(i_cache_index),
        .i_ram_wr_data(i_cache_tag)
    );

endmodule

// ==== rtl/cache_ctrl.sv ====
// cache controller FSM for lookup, write-back, fill and flush
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                 clk,
    input  logic                                 n_rst,

    input  cache_bus_pkg::cpu_req_t              i_cpu_req,
    output cache_bus_pkg::cpu_rsp_t              o_cpu_rsp,
    output logic                                 o_busy,
    output cache_bus_pkg::mem_req_t              o_mem_req,
    input  cache_bus_pkg::mem_rsp_t              i_mem_rsp,

    // array controls
    output logic                                 o_cache_re,
    output logic                                 o_cache_we,
    output logic                                 o_cache_fe,
    output logic                                 o_cache_valid,
    output logic [cache_cfg_pkg::OFFSET_WIDTH-1:0] o_cache_offset,
    output logic [cache_cfg_pkg::INDEX_WIDTH-1:0]  o_cache_index,
    output logic [cache_cfg_pkg::TAG_WIDTH-1:0]    o_cache_tag,
    output logic [cache_cfg_pkg::LINE_WIDTH-1:0]   o_cache_fdata,
    output logic [cache_cfg_pkg::DATA_WIDTH-1:0]   o_cache_wdata,

    // array status for the addressed line
    input  logic                                 i_cache_valid,
    input  logic                                 i_cache_dirty,
    input  logic                                 i_cache_hit,
    input  logic [cache_cfg_pkg::TAG_WIDTH-1:0]    i_cache_tag,
    input  logic [cache_cfg_pkg::LINE_WIDTH-1:0]   i_cache_vdata,
    input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]   i_cache_rdata
);

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    ctrl_state_e           state_q;
    ctrl_state_e           state_d;
    cache_op_e             op_q;
    addr_t                 addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [TAG_WIDTH-1:0]  victim_tag_q;
    logic [LINE_WIDTH-1:0] victim_line_q;
    logic                  done_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  accept;
    logic                  capture_victim;

    // done is registered, so busy stays up through the done cycle
    assign accept = (state_q == S_IDLE) && !done_q && i_cpu_req.valid;
    assign o_busy = (state_q != S_IDLE) || done_q;

    assign o_cache_re     = (state_q == S_LOOKUP) || (state_q == S_DONE);
    assign o_cache_we     = (state_q == S_DONE) && (op_q == OP_WRITE);
    assign o_cache_offset = addr_q.offset;
    assign o_cache_index  = addr_q.index;
    assign o_cache_tag    = addr_q.tag;
    assign o_cache_wdata  = wdata_q;

    always_comb begin
        state_d        = state_q;
        capture_victim = 1'b0;
        o_cache_fe     = 1'b0;
        o_cache_valid  = 1'b0;
        o_cache_fdata  = i_cache_vdata;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (op_q == OP_FLUSH) begin
                    if (!i_cache_hit) begin
                        state_d = S_DONE;
                    end else if (i_cache_dirty) begin
                        capture_victim = 1'b1;
                        state_d        = S_WB_REQ;
                    end else begin
                        // clean line is simply invalidated in place
                        o_cache_fe = 1'b1;
                        state_d    = S_DONE;
                    end
                end else if (i_cache_hit) begin
                    state_d = S_DONE;
                end else if (i_cache_valid && i_cache_dirty) begin
                    capture_victim = 1'b1;
                    state_d        = S_WB_REQ;
                end else begin
                    state_d = S_FILL_REQ;
                end
            end
            S_WB_REQ: begin
                state_d = S_WB_WAIT;
            end
            S_WB_WAIT: begin
                if (i_mem_rsp.ack) begin
                    if (op_q == OP_FLUSH) begin
                        o_cache_fe    = 1'b1;
                        o_cache_fdata = victim_line_q;
                        state_d       = S_DONE;
                    end else begin
                        state_d = S_FILL_REQ;
                    end
                end
            end
            S_FILL_REQ: begin
                state_d = S_FILL_WAIT;
            end
            S_FILL_WAIT: begin
                // the refilled line is looked up again and then hits
                if (i_mem_rsp.ack) begin
                    o_cache_fe    = 1'b1;
                    o_cache_valid = 1'b1;
                    o_cache_fdata = i_mem_rsp.rdata;
                    state_d       = S_LOOKUP;
                end
            end
            S_DONE: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= S_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == S_DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= i_cpu_req.op;
            addr_q  <= i_cpu_req.addr;
            wdata_q <= i_cpu_req.wdata;
        end
        if (capture_victim) begin
            victim_tag_q  <= i_cache_tag;
            victim_line_q <= i_cache_vdata;
        end
        if (state_q == S_DONE) begin
            rdata_q <= i_cache_rdata;
        end
    end

    always_comb begin
        o_cpu_rsp.done  = done_q;
        o_cpu_rsp.rdata = rdata_q;
    end

    // write-backs go to the victim's address, fills to the requested one
    always_comb begin
        o_mem_req.rd    = (state_q == S_FILL_REQ);
        o_mem_req.wr    = (state_q == S_WB_REQ);
        o_mem_req.wdata = victim_line_q;
        if (state_q == S_WB_REQ) begin
            o_mem_req.line_addr = {victim_tag_q, addr_q.index};
        end else begin
            o_mem_req.line_addr = {addr_q.tag, addr_q.index};
        end
    end

endmodule

// ==== rtl/dcache_top.sv ====
// data cache top level joining the controller and the cache array
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    n_rst,
    input  cache_bus_pkg::cpu_req_t i_cpu_req,
    output cache_bus_pkg::cpu_rsp_t o_cpu_rsp,
    output logic                    o_busy,
    output cache_bus_pkg::mem_req_t o_mem_req,
    input  cache_bus_pkg::mem_rsp_t i_mem_rsp
);

    import cache_cfg_pkg::*;

    logic                    cache_re;
    logic                    cache_we;
    logic                    cache_fe;
    logic                    fill_valid;
    logic [OFFSET_WIDTH-1:0] cache_offset;
    logic [INDEX_WIDTH-1:0]  cache_index;
    logic [TAG_WIDTH-1:0]    cache_tag;
    logic [LINE_WIDTH-1:0]   cache_fdata;
    logic [DATA_WIDTH-1:0]   cache_wdata;
    logic                    line_valid;
    logic                    line_dirty;
    logic                    line_hit;
    logic [TAG_WIDTH-1:0]    line_tag;
    logic [LINE_WIDTH-1:0]   line_vdata;
    logic [DATA_WIDTH-1:0]   line_rdata;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_cpu_req     (i_cpu_req),
        .o_cpu_rsp     (o_cpu_rsp),
        .o_busy        (o_busy),
        .o_mem_req     (o_mem_req),
        .i_mem_rsp     (i_mem_rsp),
        .o_cache_re    (cache_re),
        .o_cache_we    (cache_we),
        .o_cache_fe    (cache_fe),
        .o_cache_valid (fill_valid),
        .o_cache_offset(cache_offset),
        .o_cache_index (cache_index),
        .o_cache_tag   (cache_tag),
        .o_cache_fdata (cache_fdata),
        .o_cache_wdata (cache_wdata),
        .i_cache_valid (line_valid),
        .i_cache_dirty (line_dirty),
        .i_cache_hit   (line_hit),
        .i_cache_tag   (line_tag),
        .i_cache_vdata (line_vdata),
        .i_cache_rdata (line_rdata)
    );

    cache u_cache (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_cache_re    (cache_re),
        .i_cache_we    (cache_we),
        .i_cache_fe    (cache_fe),
        .i_cache_valid (fill_valid),
        .i_cache_offset(cache_offset),
        .i_cache_index (cache_index),
        .i_cache_tag   (cache_tag),
        .i_cache_fdata (cache_fdata),
        .i_cache_wdata (cache_wdata),
        .o_cache_valid (line_valid),
        .o_cache_dirty (line_dirty),
        .o_cache_hit   (line_hit),
        .o_cache_tag   (line_tag),
        .o_cache_vdata (line_vdata),
        .o_cache_rdata (line_rdata)
    );

endmodule

// ==== dv/dcache_props.sv ====
// bound assertions on the cache controller done pulse and memory strobes
`timescale 1ns/1ps

module dcache_props (
    input  logic                    clk,
    input  logic                    n_rst,
    input  cache_bus_pkg::cpu_rsp_t i_cpu_rsp,
    input  logic                    i_busy,
    input  cache_bus_pkg::mem_req_t i_mem_req
);

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        i_cpu_rsp.done |=> !i_cpu_rsp.done)
        else $error("done stayed high for more than one cycle");

    // only one memory transaction direction at a time
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_mem_req.rd && i_mem_req.wr))
        else $error("memory read and write strobes are high together");

    a_strobe_busy: assert property (@(posedge clk) disable iff (!n_rst)
        (i_mem_req.rd || i_mem_req.wr) |-> i_busy)
        else $error("memory strobe issued while the controller is not busy");

endmodule

bind cache_ctrl dcache_props u_props (
    .clk      (clk),
    .n_rst    (n_rst),
    .i_cpu_rsp(o_cpu_rsp),
    .i_busy   (o_busy),
    .i_mem_req(o_mem_req)
);

// ==== dv/dcache_tb.sv ====
// data cache testbench with clock, reset, memory model, shadow memory and directed tests
`timescale 1ns/1ps

module dcache_tb;

    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;

    localparam logic [31:0] SEED           = 32'h4d75_3edb;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          MEM_BYTES      = 65536;

    logic        clk = 1'b0;
    logic        n_rst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    logic        busy;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [7:0]            mem_bytes    [MEM_BYTES];
    logic [7:0]            shadow_bytes [MEM_BYTES];
    int                    mem_reads;
    int                    mem_writes;
    logic [11:0]           last_wr_addr;
    logic [LINE_WIDTH-1:0] last_wr_line;
    logic [31:0]           rand_state;
    logic [31:0]           lat_state;
    int                    checks;
    int                    errors;
    logic                  timed_out;

    always #10 clk = ~clk;

    dcache_top dut (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_cpu_req(cpu_req),
        .o_cpu_rsp(cpu_rsp),
        .o_busy   (busy),
        .o_mem_req(mem_req),
        .i_mem_rsp(mem_rsp)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [15:0] addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    function automatic logic [31:0] shadow_word(input logic [15:0] addr);
        return {shadow_bytes[addr + 16'd3], shadow_bytes[addr + 16'd2],
                shadow_bytes[addr + 16'd1], shadow_bytes[addr]};
    endfunction

    function automatic logic [31:0] memory_word(input logic [15:0] addr);
        return {mem_bytes[addr + 16'd3], mem_bytes[addr + 16'd2],
                mem_bytes[addr + 16'd1], mem_bytes[addr]};
    endfunction

    function automatic void write_shadow(input logic [15:0] addr, input logic [31:0] data);
        shadow_bytes[addr]         = data[7:0];
        shadow_bytes[addr + 16'd1] = data[15:8];
        shadow_bytes[addr + 16'd2] = data[23:16];
        shadow_bytes[addr + 16'd3] = data[31:24];
    endfunction

    // byte k of a line sits in bits k*8 upward, words are little endian
    function automatic logic [31:0] line_word(input logic [LINE_WIDTH-1:0] line,
                                              input logic [3:0] offset);
        logic [LINE_WIDTH-1:0] shifted;
        shifted = line >> (32'(offset) * 8);
        return shifted[31:0];
    endfunction

    // random traffic lives in tags 0x40..0x43 and indices 8..10
    function automatic logic [15:0] make_addr(input int t, input int i, input int o);
        return {8'h40 + 8'(t), 4'(8 + i), 4'(o * 4)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // line-wide memory answering each strobe after 1 to 8 cycles
    initial begin : memory_model
        logic [15:0]           base;
        logic [LINE_WIDTH-1:0] line;
        int                    lat;
        mem_rsp      = '0;
        mem_reads    = 0;
        mem_writes   = 0;
        last_wr_addr = '0;
        last_wr_line = '0;
        lat_state    = SEED;
        for (int a = 0; a < MEM_BYTES; a++) begin
            base             = 16'(a);
            mem_bytes[base] = pattern_byte(base);
        end
        forever begin
            @(negedge clk);
            if (n_rst && (mem_req.rd || mem_req.wr)) begin
                base = {mem_req.line_addr, 4'h0};
                line = '0;
                if (mem_req.rd) begin
                    mem_reads++;
                    for (int k = 0; k < LINE_BYTES; k++) begin
                        line = {mem_bytes[base + 16'(k)], line[LINE_WIDTH-1:8]};
                    end
                end else begin
                    mem_writes++;
                    last_wr_addr = mem_req.line_addr;
                    last_wr_line = mem_req.wdata;
                    line         = mem_req.wdata;
                    for (int k = 0; k < LINE_BYTES; k++) begin
                        mem_bytes[base + 16'(k)] = line[7:0];
                        line = line >> 8;
                    end
                end
                lat_state = lcg_step(lat_state);
                lat       = int'(lat_state[18:16]) + 1;
                repeat (lat) @(posedge clk);
                #2;
                mem_rsp.ack   = 1'b1;
                mem_rsp.rdata = line;
                @(posedge clk);
                #2;
                mem_rsp.ack   = 1'b0;
                mem_rsp.rdata = '0;
            end
        end
    end

    // edges counts clock edges from acceptance to the start of the done cycle
    task automatic issue_request(input string name, input cache_op_e op,
                                 input logic [15:0] addr, input logic [31:0] wdata,
                                 output logic [31:0] rdata, output int edges);
        int   n;
        logic seen;
        rdata = '0;
        edges = -1;
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        #2;
        n = 0;
        while (busy && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy) begin
            $display("Timeout: %s found the cache still busy after %0d cycles", name, n);
            errors++;
            timed_out = 1'b1;
            return;
        end
        cpu_req.valid = 1'b1;
        cpu_req.op    = op;
        cpu_req.addr  = addr_t'(addr);
        cpu_req.wdata = wdata;
        @(posedge clk);
        #2;
        cpu_req.valid = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
            seen = cpu_rsp.done;
        end
        if (!seen) begin
            $display("Timeout: %s got no done within %0d cycles", name, n);
            errors++;
            timed_out = 1'b1;
            return;
        end
        rdata = cpu_rsp.rdata;
        edges = n - 1;
        if (op == OP_WRITE) begin
            write_shadow(addr, wdata);
        end
    endtask

    task automatic cold_read_miss();
        logic [31:0] rdata;
        int          edges;
        int          reads0;
        reads0 = mem_reads;
        issue_request("cold_read_miss", OP_READ, 16'h0124, '0, rdata, edges);
        check_value("cold_read_miss data", shadow_word(16'h0124), rdata);
        check_value("cold_read_miss reads", 32'(reads0 + 1), 32'(mem_reads));
        issue_request("cold_read_miss repeat", OP_READ, 16'h0128, '0, rdata, edges);
        check_value("cold_read_miss repeat data", shadow_word(16'h0128), rdata);
        check_value("cold_read_miss repeat reads", 32'(reads0 + 1), 32'(mem_reads));
        check_value("cold_read_miss hit latency", 32'd2, 32'(edges));
    endtask

    task automatic write_hit();
        logic [31:0] rdata;
        int          edges;
        int          reads0;
        int          writes0;
        reads0  = mem_reads;
        writes0 = mem_writes;
        issue_request("write_hit write", OP_WRITE, 16'h0128, 32'hcafe_0001, rdata, edges);
        check_value("write_hit write latency", 32'd2, 32'(edges));
        issue_request("write_hit read", OP_READ, 16'h0128, '0, rdata, edges);
        check_value("write_hit new word", 32'hcafe_0001, rdata);
        issue_request("write_hit low", OP_READ, 16'h0120, '0, rdata, edges);
        check_value("write_hit low word", shadow_word(16'h0120), rdata);
        issue_request("write_hit high", OP_READ, 16'h012c, '0, rdata, edges);
        check_value("write_hit high word", shadow_word(16'h012c), rdata);
        check_value("write_hit reads", 32'(reads0), 32'(mem_reads));
        check_value("write_hit writes", 32'(writes0), 32'(mem_writes));
    endtask

    task automatic conflict_eviction();
        logic [31:0] rdata;
        int          edges;
        int          reads0;
        int          writes0;
        issue_request("conflict_eviction write", OP_WRITE, 16'h0230, 32'h1234_5678,
                      rdata, edges);
        reads0  = mem_reads;
        writes0 = mem_writes;
        issue_request("conflict_eviction read", OP_READ, 16'h0530, '0, rdata, edges);
        check_value("conflict_eviction data", shadow_word(16'h0530), rdata);
        check_value("conflict_eviction writes", 32'(writes0 + 1), 32'(mem_writes));
        check_value("conflict_eviction reads", 32'(reads0 + 1), 32'(mem_reads));
        check_value("conflict_eviction victim addr", 32'h023, 32'(last_wr_addr));
        check_value("conflict_eviction victim word", 32'h1234_5678,
                    line_word(last_wr_line, 4'h0));
        issue_request("conflict_eviction reread", OP_READ, 16'h0230, '0, rdata, edges);
        check_value("conflict_eviction reread data", 32'h1234_5678, rdata);
    endtask

    task automatic flush_lines();
        logic [31:0] rdata;
        int          edges;
        int          reads0;
        int          writes0;
        issue_request("flush write", OP_WRITE, 16'h0344, 32'hdead_beef, rdata, edges);
        writes0 = mem_writes;
        issue_request("flush dirty", OP_FLUSH, 16'h0344, '0, rdata, edges);
        check_value("flush dirty writes", 32'(writes0 + 1), 32'(mem_writes));
        check_value("flush dirty addr", 32'h034, 32'(last_wr_addr));
        check_value("flush dirty word", 32'hdead_beef, line_word(last_wr_line, 4'h4));
        reads0 = mem_reads;
        issue_request("flush reread", OP_READ, 16'h0344, '0, rdata, edges);
        check_value("flush reread data", 32'hdead_beef, rdata);
        check_value("flush reread reads", 32'(reads0 + 1), 32'(mem_reads));
        writes0 = mem_writes;
        issue_request("flush clean", OP_FLUSH, 16'h0344, '0, rdata, edges);
        check_value("flush clean latency", 32'd2, 32'(edges));
        issue_request("flush absent", OP_FLUSH, 16'h0744, '0, rdata, edges);
        check_value("flush absent latency", 32'd2, 32'(edges));
        check_value("flush clean and absent writes", 32'(writes0), 32'(mem_writes));
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [15:0] addr;
        int          edges;
        for (int n = 0; n < 200; n++) begin
            rand_state = lcg_step(rand_state);
            r          = rand_state;
            rand_state = lcg_step(rand_state);
            wdata      = rand_state;
            addr = make_addr(int'(r[17:16]), int'(r[23:20]) % 3, int'(r[25:24]));
            if (r[30:28] < 3'd4) begin
                issue_request("random_traffic read", OP_READ, addr, '0, rdata, edges);
                check_value($sformatf("random_traffic read %h", addr),
                            shadow_word(addr), rdata);
            end else if (r[30:28] < 3'd7) begin
                issue_request("random_traffic write", OP_WRITE, addr, wdata, rdata, edges);
            end else begin
                issue_request("random_traffic flush", OP_FLUSH, addr, '0, rdata, edges);
            end
        end
        // one flush per tag and index pushes every dirty line out
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 3; i++) begin
                issue_request("random_traffic final flush", OP_FLUSH, make_addr(t, i, 0),
                              '0, rdata, edges);
            end
        end
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 3; i++) begin
                for (int o = 0; o < 4; o++) begin
                    addr = make_addr(t, i, o);
                    check_value($sformatf("random_traffic memory %h", addr),
                                shadow_word(addr), memory_word(addr));
                end
            end
        end
    endtask

    initial begin : main
        logic [15:0] a16;
        cpu_req    = '0;
        n_rst      = 1'b0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        rand_state = SEED;
        for (int a = 0; a < MEM_BYTES; a++) begin
            a16               = 16'(a);
            shadow_bytes[a16] = pattern_byte(a16);
        end
        repeat (10) @(posedge clk);
        #2;
        n_rst = 1'b1;
        @(negedge clk);
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset done", 32'd0, 32'(cpu_rsp.done));
        check_value("reset mem strobes", 32'd0, 32'({mem_req.rd, mem_req.wr}));
        cold_read_miss();
        write_hit();
        conflict_eviction();
        flush_lines();
        random_traffic();
        $display("checks: %0d  errors: %0d  memory reads: %0d  memory writes: %0d",
                 checks, errors, mem_reads, mem_writes);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/cache_cfg_pkg.sv
rtl/cache_bus_pkg.sv
rtl/dp_ram.sv
rtl/cache.sv
rtl/cache_ctrl.sv
rtl/dcache_top.sv
dv/dcache_props.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the data cache testbench with Verilator, run it, and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module dcache_tb --Mdir obj_dir \
    -o dcache_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } || exit 0
